//--- files.f
+incdir+verilog
verilog/signal_pkg.sv
verilog/control_pkg.sv
verilog/moving_average_filter.sv
verilog/mode_supervisor.sv
verilog/pi_controller.sv
verilog/hybrid_control_top.sv
dv/hybrid_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hybrid control testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps \
   --top-module hybrid_control_tb -f files.f -o hybrid_control_sim \
   && ./obj_dir/hybrid_control_sim > sim.log 2>&1 \
   || echo "build or simulation did not complete"

cat sim.log 2>/dev/null

grep -qxF "*** TEST PASSED ***" sim.log 2>/dev/null \
   && echo "simulation passed" && exit 0 \
   || { echo "simulation failed"; exit 1; }

//--- dv/hybrid_control_tb.sv
`include "hybrid_control_defines.svh"

module hybrid_control_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int SHORT_TAPS = 1 << `HC_SHORT_TAPS_LOG2;
   localparam int LONG_TAPS  = 1 << `HC_LONG_TAPS_LOG2;
   localparam int NUM_ROWS   = 11;

   // one stimulus row
   // noise_bits of 0 means a clean measurement
   typedef struct packed {
      int measure;
      int setpoint;
      int count;
      int noise_bits;
   } stim_row_t;

   // measure, setpoint, cycles, noise bits
   stim_row_t stim_table [NUM_ROWS] = '{
      '{0, 0, 4, 0},
      // constant level while the long filter fills up
      '{1000, 1000, 40, 0},
      // negative odd step with floor means
      '{-777, -700, 40, 0},
      // setpoint jump past the enter threshold
      '{-777, 5000, 20, 0},
      // error inside the band holds the mode
      '{3000, 5000, 12, 0},
      // small error returns to slow
      '{4900, 5000, 20, 0},
      // drive into the positive limit
      '{-200000, 200000, 60, 0},
      // reverse out of the positive limit into the negative one
      '{200000, -200000, 100, 0},
      '{0, 0, 40, 0},
      // noisy tracking
      '{2000, 2000, 80, 10},
      '{-3001, -3000, 60, 12}
   };

   logic                    i_clock;
   logic                    i_RESET;
   signal_pkg::sample_t     i_measure;
   signal_pkg::sample_t     i_setpoint;
   signal_pkg::sample_t     o_filtered;
   control_pkg::mode_t      o_mode;
   control_pkg::actuation_t o_actuation;

   // reference model state
   int          short_hist [SHORT_TAPS];
   int          long_hist [LONG_TAPS];
   bit          model_fast;
   longint      model_integ;
   longint      model_act;
   bit          model_sat;
   logic [15:0] lfsr_state = 16'd21;
   int          error_count;
   int          check_count;

   hybrid_control_top UUT (
      .i_clock     (i_clock),
      .i_RESET     (i_RESET),
      .i_measure   (i_measure),
      .i_setpoint  (i_setpoint),
      .o_filtered  (o_filtered),
      .o_mode      (o_mode),
      .o_actuation (o_actuation)
   );

   // ----------------------------------------------------------------------
   // clock
   // ----------------------------------------------------------------------
   initial begin
      i_clock = 1'b0;
      forever begin
         #10 i_clock = ~i_clock;
      end
   end

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------
   task automatic expect_equal(
      input logic signed [63:0] actual,
      input logic signed [63:0] expected,
      input string              what
   );
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      end
   endtask

   // 16 bit galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      logic [15:0] stepped;
      stepped = state >> 1;
      if (state[0]) begin
         stepped = stepped ^ 16'hB400;
      end
      return stepped;
   endfunction

   // one LFSR step per noise bit
   // result centred on zero
   task automatic draw_noise(input int bits, output int value);
      int raw;
      raw = 0;
      for (int b = 0; b < bits; b++) begin
         raw = (raw << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_step(lfsr_state);
      end
      value = raw - (1 << (bits - 1));
   endtask

   // floor division for a positive den
   function automatic longint floor_div(input longint num, input longint den);
      longint quot;
      quot = num / den;
      if ((num % den != 0) && (num < 0)) begin
         quot = quot - 1;
      end
      return quot;
   endfunction

   function automatic longint clamp_limit(input longint value);
      longint result;
      result = value;
      if (value > `HC_OUT_LIMIT) begin
         result = `HC_OUT_LIMIT;
      end else if (value < -`HC_OUT_LIMIT) begin
         result = -`HC_OUT_LIMIT;
      end
      return result;
   endfunction

   // mean of the model history of one filter
   function automatic longint window_mean(input bit use_short);
      longint sum;
      sum = 0;
      if (use_short) begin
         for (int i = 0; i < SHORT_TAPS; i++) begin
            sum += longint'(short_hist[i]);
         end
         return floor_div(sum, longint'(SHORT_TAPS));
      end
      for (int i = 0; i < LONG_TAPS; i++) begin
         sum += longint'(long_hist[i]);
      end
      return floor_div(sum, longint'(LONG_TAPS));
   endfunction

   // ----------------------------------------------------------------------
   // reference model, one clock edge
   // ----------------------------------------------------------------------
   task automatic model_step(input int meas, input int sp);
      longint mean;
      longint err;
      longint mag;
      longint p_term;
      longint i_term;
      longint act_sum;
      int     kp;
      int     ki;
      // error from the state before the edge
      mean = window_mean(model_fast);
      err  = longint'(int'(longint'(sp) - mean));
      mag  = (err < 0) ? -err : err;
      if (model_fast) begin
         kp = int'(`HC_FAST_KP_SHIFT);
         ki = int'(`HC_FAST_KI_SHIFT);
      end else begin
         kp = int'(`HC_SLOW_KP_SHIFT);
         ki = int'(`HC_SLOW_KI_SHIFT);
      end
      // PI update with the integrator first
      p_term      = floor_div(err, longint'(1) << kp);
      i_term      = floor_div(err, longint'(1) << ki);
      model_integ = clamp_limit(model_integ + i_term);
      act_sum     = p_term + model_integ;
      model_act   = clamp_limit(act_sum);
      model_sat   = (model_act != act_sum);
      // hysteresis
      if (!model_fast && (mag > `HC_ENTER_FAST_TH)) begin
         model_fast = 1'b1;
      end else if (model_fast && (mag < `HC_EXIT_FAST_TH)) begin
         model_fast = 1'b0;
      end
      // newest sample at index 0
      for (int i = SHORT_TAPS - 1; i > 0; i--) begin
         short_hist[i] = short_hist[i-1];
      end
      short_hist[0] = meas;
      for (int i = LONG_TAPS - 1; i > 0; i--) begin
         long_hist[i] = long_hist[i-1];
      end
      long_hist[0] = meas;
   endtask

   task automatic check_outputs(input string phase);
      expect_equal(64'(o_mode), 64'(model_fast), {phase, " o_mode"});
      expect_equal(64'($signed(o_filtered)), window_mean(model_fast),
                   {phase, " o_filtered"});
      expect_equal(64'($signed(o_actuation.value)), model_act,
                   {phase, " actuation value"});
      expect_equal(64'(o_actuation.saturated), 64'(model_sat),
                   {phase, " actuation saturated"});
   endtask

   // ----------------------------------------------------------------------
   // stimulus and checks
   // ----------------------------------------------------------------------
   initial begin
      int applied_measure;
      int applied_setpoint;
      int next_measure;
      int noise;
      i_RESET          = 1'b0;
      i_measure        = '0;
      i_setpoint       = '0;
      applied_measure  = 0;
      applied_setpoint = 0;
      error_count      = 0;
      check_count      = 0;
      // model starts in its reset state
      repeat (2) begin
         @(negedge i_clock);
         check_outputs("in reset");
      end
      @(posedge i_clock);
      i_RESET <= 1'b1;
      @(negedge i_clock);
      check_outputs("after reset");

      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int n = 0; n < stim_table[r].count; n++) begin
            @(posedge i_clock);
            // DUT and model take the same inputs at this edge
            model_step(applied_measure, applied_setpoint);
            next_measure = stim_table[r].measure;
            if (stim_table[r].noise_bits != 0) begin
               draw_noise(stim_table[r].noise_bits, noise);
               next_measure = next_measure + noise;
            end
            i_measure        <= next_measure;
            i_setpoint       <= stim_table[r].setpoint;
            applied_measure  = next_measure;
            applied_setpoint = stim_table[r].setpoint;
            // outputs settled by mid cycle
            @(negedge i_clock);
            check_outputs($sformatf("row %0d cycle %0d", r, n));
         end
      end

      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // ----------------------------------------------------------------------
   // watchdog
   // ----------------------------------------------------------------------
   initial begin : watchdog
      int total;
      total = 0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         total += stim_table[r].count;
      end
      // margin covers reset and release
      #((total + 50) * 20);
      $display("timeout: the run did not finish within %0d clock cycles", total + 50);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- verilog/hybrid_control_top.sv
`include "hybrid_control_defines.svh"

module hybrid_control_top (
   input  logic                    i_clock,
   input  logic                    i_RESET,
   input  signal_pkg::sample_t     i_measure,
   input  signal_pkg::sample_t     i_setpoint,
   output signal_pkg::sample_t     o_filtered,
   output control_pkg::mode_t      o_mode,
   output control_pkg::actuation_t o_actuation
);

   signal_pkg::sample_t    short_mean;
   signal_pkg::sample_t    long_mean;
   signal_pkg::filt_pair_t means;
   control_pkg::ctrl_err_t ctrl_err;

   // ----------------------------------------------------------------------
   // filters
   // ----------------------------------------------------------------------
   // 4 taps, quick response
   moving_average_filter #(
      .TAPS_LOG2 (`HC_SHORT_TAPS_LOG2)
   ) short_filter (
      .i_clock (i_clock),
      .i_RESET (i_RESET),
      .i_data  (i_measure),
      .o_mean  (short_mean)
   );

   // 32 taps, low noise
   moving_average_filter #(
      .TAPS_LOG2 (`HC_LONG_TAPS_LOG2)
   ) long_filter (
      .i_clock (i_clock),
      .i_RESET (i_RESET),
      .i_data  (i_measure),
      .o_mean  (long_mean)
   );

   assign means = '{short_mean: short_mean, long_mean: long_mean};

   // ----------------------------------------------------------------------
   // mode supervisor
   // ----------------------------------------------------------------------
   // picks the filter and the gains
   mode_supervisor supervisor (
      .i_clock    (i_clock),
      .i_RESET    (i_RESET),
      .i_setpoint (i_setpoint),
      .i_means    (means),
      .o_mode     (o_mode),
      .o_filtered (o_filtered),
      .o_ctrl_err (ctrl_err)
   );

   // ----------------------------------------------------------------------
   // PI controller
   // ----------------------------------------------------------------------
   // registered actuation, one edge after the error
   pi_controller controller (
      .i_clock     (i_clock),
      .i_RESET     (i_RESET),
      .i_ctrl_err  (ctrl_err),
      .o_actuation (o_actuation)
   );

endmodule

//--- verilog/pi_controller.sv
`include "hybrid_control_defines.svh"

module pi_controller (
   input  logic                    i_clock,
   input  logic                    i_RESET,
   input  control_pkg::ctrl_err_t  i_ctrl_err,
   output control_pkg::actuation_t o_actuation
);

   // two guard bits, sums of clamped terms never wrap
   localparam int WIDE = `HC_DATA_WIDTH + 2;
   localparam logic signed [WIDE-1:0] POS_LIMIT = WIDE'(`HC_OUT_LIMIT);
   localparam logic signed [WIDE-1:0] NEG_LIMIT = -POS_LIMIT;

   signal_pkg::sample_t     integ_q;
   signal_pkg::sample_t     integ_d;
   control_pkg::actuation_t act_q;
   control_pkg::actuation_t act_d;

   logic signed [WIDE-1:0]  err_wide;
   logic signed [WIDE-1:0]  p_term;
   logic signed [WIDE-1:0]  i_term;
   logic signed [WIDE-1:0]  integ_sum;
   logic signed [WIDE-1:0]  integ_clamped;
   logic signed [WIDE-1:0]  act_sum;
   logic signed [WIDE-1:0]  act_clamped;

   // limit to +-OUT_LIMIT
   function automatic logic signed [WIDE-1:0] clamp_word(
      input logic signed [WIDE-1:0] value
   );
      logic signed [WIDE-1:0] result;
      result = value;
      if (value > POS_LIMIT) begin
         result = POS_LIMIT;
      end else if (value < NEG_LIMIT) begin
         result = NEG_LIMIT;
      end
      return result;
   endfunction

   // ----------------------------------------------------------------------
   // proportional and integral terms
   // ----------------------------------------------------------------------
   assign err_wide = WIDE'(i_ctrl_err.error);

   // shift gains, rounding toward minus infinity
   assign p_term = err_wide >>> i_ctrl_err.gain.kp_shift;
   assign i_term = err_wide >>> i_ctrl_err.gain.ki_shift;

   // integrator clamped every cycle
   // no windup past the limit
   assign integ_sum     = WIDE'(integ_q) + i_term;
   assign integ_clamped = clamp_word(integ_sum);
   assign integ_d       = integ_clamped[`HC_DATA_WIDTH-1:0];

   // ----------------------------------------------------------------------
   // output sum and saturation
   // ----------------------------------------------------------------------
   // uses the updated integrator
   assign act_sum     = p_term + integ_clamped;
   assign act_clamped = clamp_word(act_sum);

   always_comb begin
      act_d.value     = act_clamped[`HC_DATA_WIDTH-1:0];
      // flag only when the limit cut the sum
      act_d.saturated = (act_clamped != act_sum);
   end

   always_ff @(posedge i_clock or negedge i_RESET) begin
      if (!i_RESET) begin
         integ_q <= '0;
         act_q   <= '0;
      end else begin
         integ_q <= integ_d;
         act_q   <= act_d;
      end
   end

   assign o_actuation = act_q;

endmodule

//--- verilog/mode_supervisor.sv
`include "hybrid_control_defines.svh"

module mode_supervisor (
   input  logic                   i_clock,
   input  logic                   i_RESET,
   input  signal_pkg::sample_t    i_setpoint,
   input  signal_pkg::filt_pair_t i_means,
   output control_pkg::mode_t     o_mode,
   output signal_pkg::sample_t    o_filtered,
   output control_pkg::ctrl_err_t o_ctrl_err
);

   // one extra bit so |most negative| still fits
   localparam int MAG_WIDTH = `HC_DATA_WIDTH + 1;
   localparam logic signed [MAG_WIDTH-1:0] ENTER_TH = MAG_WIDTH'(`HC_ENTER_FAST_TH);
   localparam logic signed [MAG_WIDTH-1:0] EXIT_TH = MAG_WIDTH'(`HC_EXIT_FAST_TH);

   control_pkg::mode_t          mode_q;
   control_pkg::mode_t          mode_d;
   signal_pkg::sample_t         selected_mean;
   signal_pkg::sample_t         err_word;
   logic signed [MAG_WIDTH-1:0] err_wide;
   logic signed [MAG_WIDTH-1:0] err_mag;
   control_pkg::gain_t          gain;

   // ----------------------------------------------------------------------
   // filter selection and error
   // ----------------------------------------------------------------------
   // fast mode follows the short filter
   assign selected_mean = (mode_q == control_pkg::MODE_FAST) ?
                          i_means.short_mean : i_means.long_mean;

   // wraps at the data width
   assign err_word = i_setpoint - selected_mean;
   assign err_wide = MAG_WIDTH'(err_word);
   assign err_mag  = (err_wide < 0) ? -err_wide : err_wide;

   // gain set of the current mode
   always_comb begin
      if (mode_q == control_pkg::MODE_FAST) begin
         gain.kp_shift = `HC_FAST_KP_SHIFT;
         gain.ki_shift = `HC_FAST_KI_SHIFT;
      end else begin
         gain.kp_shift = `HC_SLOW_KP_SHIFT;
         gain.ki_shift = `HC_SLOW_KI_SHIFT;
      end
   end

   // ----------------------------------------------------------------------
   // hysteresis
   // ----------------------------------------------------------------------
   always_comb begin
      mode_d = mode_q;
      case (mode_q)
         // large error, go hard
         control_pkg::MODE_SLOW: begin
            if (err_mag > ENTER_TH) begin
               mode_d = control_pkg::MODE_FAST;
            end
         end
         // settle back only well inside the band
         control_pkg::MODE_FAST: begin
            if (err_mag < EXIT_TH) begin
               mode_d = control_pkg::MODE_SLOW;
            end
         end
         default: mode_d = control_pkg::MODE_SLOW;
      endcase
   end

   always_ff @(posedge i_clock or negedge i_RESET) begin
      if (!i_RESET) begin
         mode_q <= control_pkg::MODE_SLOW;
      end else begin
         mode_q <= mode_d;
      end
   end

   assign o_mode     = mode_q;
   assign o_filtered = selected_mean;
   assign o_ctrl_err = '{error: err_word, gain: gain};

endmodule

//--- verilog/moving_average_filter.sv
`include "hybrid_control_defines.svh"

module moving_average_filter #(
   parameter int TAPS_LOG2 = 2
) (
   input  logic                i_clock,
   input  logic                i_RESET,
   input  signal_pkg::sample_t i_data,
   output signal_pkg::sample_t o_mean
);

   // number of stored samples
   localparam int TAPS = 1 << TAPS_LOG2;
   // sum of TAPS words needs TAPS_LOG2 extra bits
   localparam int ACC_WIDTH = `HC_DATA_WIDTH + TAPS_LOG2;

   // newest sample at index 0
   signal_pkg::sample_t          delay_line [TAPS];
   logic signed [ACC_WIDTH-1:0]  acc_sum;
   logic signed [ACC_WIDTH-1:0]  acc_shifted;

   // ----------------------------------------------------------------------
   // delay line
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clock or negedge i_RESET) begin
      if (!i_RESET) begin
         for (int i = 0; i < TAPS; i++) begin
            delay_line[i] <= '0;
         end
      end else begin
         delay_line[0] <= i_data;
         // shift older samples down the line
         for (int i = 1; i < TAPS; i++) begin
            delay_line[i] <= delay_line[i-1];
         end
      end
   end

   // ----------------------------------------------------------------------
   // mean
   // ----------------------------------------------------------------------
   always_comb begin
      acc_sum = '0;
      // sign extend each tap into the wide accumulator
      for (int i = 0; i < TAPS; i++) begin
         acc_sum = acc_sum + ACC_WIDTH'(delay_line[i]);
      end
      // arithmetic shift, floor of the true mean
      acc_shifted = acc_sum >>> TAPS_LOG2;
   end

   // mean always fits back in one data word
   assign o_mean = acc_shifted[`HC_DATA_WIDTH-1:0];

endmodule

//--- verilog/control_pkg.sv
`include "hybrid_control_defines.svh"

// ----------------------------------------------------------------------
// types for control decisions
// ----------------------------------------------------------------------
package control_pkg;

   // regulator operating mode
   // slow is the reset value
   typedef enum logic {
      MODE_SLOW = 1'b0,
      MODE_FAST = 1'b1
   } mode_t;

   // gain set as right shift amounts
   typedef struct packed {
      logic [`HC_SHIFT_WIDTH-1:0] kp_shift;
      logic [`HC_SHIFT_WIDTH-1:0] ki_shift;
   } gain_t;

   // error word plus the gains that go with it
   typedef struct packed {
      signal_pkg::sample_t error;
      gain_t               gain;
   } ctrl_err_t;

   // actuation word
   // saturated flags a clamped output
   typedef struct packed {
      signal_pkg::sample_t value;
      logic                saturated;
   } actuation_t;

endpackage

//--- verilog/signal_pkg.sv
`include "hybrid_control_defines.svh"

// ----------------------------------------------------------------------
// types for measured and filtered signal samples
// ----------------------------------------------------------------------
package signal_pkg;

   // one signed measurement word
   // same format for raw and filtered samples
   typedef logic signed [`HC_DATA_WIDTH-1:0] sample_t;

   // both filter outputs, bundled for the supervisor
   // short_mean tracks fast, long_mean is the quiet one
   typedef struct packed {
      sample_t short_mean;
      sample_t long_mean;
   } filt_pair_t;

endpackage

//--- verilog/hybrid_control_defines.svh
`ifndef HYBRID_CONTROL_DEFINES_SVH
`define HYBRID_CONTROL_DEFINES_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
// samples, errors and actuation words
`define HC_DATA_WIDTH 32
// width of one gain shift field
`define HC_SHIFT_WIDTH 5

// ----------------------------------------------------------------------
// filter lengths, as log2 of the number of taps
// ----------------------------------------------------------------------
`define HC_SHORT_TAPS_LOG2 2
`define HC_LONG_TAPS_LOG2 5

// ----------------------------------------------------------------------
// gains as right shifts, bigger shift means softer gain
// ----------------------------------------------------------------------
`define HC_FAST_KP_SHIFT 5'd1
`define HC_FAST_KI_SHIFT 5'd4
`define HC_SLOW_KP_SHIFT 5'd3
`define HC_SLOW_KI_SHIFT 5'd6

// hysteresis band on |error|
`define HC_ENTER_FAST_TH 4096
`define HC_EXIT_FAST_TH 1024

// symmetric clamp, integrator and output
`define HC_OUT_LIMIT 1000000

`endif
